/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	localparam int TIMEOUT = 400;

	logic                clk;
	logic                por_rst_n;
	logic                rst_q;
	wire                 rst_n;
	cpu_isa_pkg::iaddr_t imem_addr;
	cpu_isa_pkg::word_t  imem_data;
	cpu_isa_pkg::daddr_t dmem_addr;
	cpu_isa_pkg::word_t  dmem_wdata;
	cpu_isa_pkg::word_t  dmem_rdata;
	logic                dmem_we;
	logic                halted;
	cpu_isa_pkg::word_t  imem [256];
	cpu_isa_pkg::word_t  dmem [256];
	int                  errors;
	int                  checks;
	int                  fill_ptr;
	int                  seed;

	tb_clock clock_i (.clk_o(clk), .rst_n_o(por_rst_n));

	// test reset on top of power-on reset
	assign rst_n = por_rst_n & rst_q;

	cpu_top dut_i (
		.clk(clk), .rst_n_i(rst_n),
		.imem_addr_o(imem_addr), .imem_data_i(imem_data),
		.dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
		.dmem_rdata_i(dmem_rdata), .halted_o(halted)
	);

	////////////////////////////////////////////////////////////
	// memory models
	////////////////////////////////////////////////////////////
	assign imem_data  = imem[imem_addr];
	assign dmem_rdata = dmem[dmem_addr];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr] <= dmem_wdata;
		end
	end

	// untouched data word
	function automatic cpu_isa_pkg::word_t fill_of(input int a);
		return {8'hd0, a[7:0]};
	endfunction

	// instruction assembly
	function automatic cpu_isa_pkg::word_t enc_r(input cpu_isa_pkg::opcode_t op,
		input cpu_isa_pkg::reg_idx_t rd, input cpu_isa_pkg::reg_idx_t rs,
		input cpu_isa_pkg::reg_idx_t rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	function automatic cpu_isa_pkg::word_t enc_i(input cpu_isa_pkg::opcode_t op,
		input cpu_isa_pkg::reg_idx_t rd, input cpu_isa_pkg::reg_idx_t rs, input logic [5:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic cpu_isa_pkg::word_t enc_li(input cpu_isa_pkg::reg_idx_t rd,
		input logic [7:0] imm);
		return {cpu_isa_pkg::OP_LI, rd, 1'b0, imm};
	endfunction

	function automatic cpu_isa_pkg::word_t sext6(input logic [5:0] v);
		return {{10{v[5]}}, v};
	endfunction

	// unused slots hold halt, low bits tag the address
	task automatic clear_mems();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {cpu_isa_pkg::OP_HALT, 4'h0, i[7:0]};
			dmem[i] <= fill_of(i);
		end
		fill_ptr = 0;
	endtask

	task automatic put(input cpu_isa_pkg::word_t w);
		imem[fill_ptr] = w;
		fill_ptr++;
	endtask

	task automatic check_word(input int addr, input cpu_isa_pkg::word_t exp, input string what);
		checks++;
		assert (dmem[addr] === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s, dmem[%02h] = %04h, expected %04h",
				$time, what, addr, dmem[addr], exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// reset pulse and run to halt
	////////////////////////////////////////////////////////////
	task automatic run_program(input string name);
		int cyc;
		@(posedge clk);
		rst_q <= 1'b0;
		// no store strobe in reset
		repeat (4) begin
			@(negedge clk);
			checks++;
			assert (dmem_we === 1'b0) else begin
				errors++;
				$display("%s: store strobe active during reset", name);
			end
		end
		@(posedge clk);
		rst_q <= 1'b1;
		@(negedge clk);
		checks++;
		assert (dmem_we === 1'b0 && halted === 1'b0) else begin
			errors++;
			$display("%s: store strobe or halt active right after reset", name);
		end
		cyc = 0;
		while (halted !== 1'b1 && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("%s: timed out waiting for the core to halt", name);
		end
		@(negedge clk);
	endtask

	// reset lands while stores stream through mem
	task automatic reset_during_stores();
		int cyc;
		clear_mems();
		for (int i = 0; i < 16; i++) begin
			put(enc_i(cpu_isa_pkg::OP_SW, 3'd0, 3'd0, i[5:0]));
		end
		@(posedge clk);
		rst_q <= 1'b0;
		@(posedge clk);
		rst_q <= 1'b1;
		cyc = 0;
		@(negedge clk);
		while (dmem_we !== 1'b1 && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (dmem_we !== 1'b1) begin
			errors++;
			$display("no store strobe seen before the mid-run reset");
		end
		@(posedge clk);
		rst_q <= 1'b0;
		@(negedge clk);
		checks++;
		assert (dmem_we === 1'b0) else begin
			errors++;
			$display("store strobe still active after reset was asserted");
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic arith_test();
		cpu_isa_pkg::word_t a;
		cpu_isa_pkg::word_t b;
		cpu_isa_pkg::word_t s3;
		cpu_isa_pkg::word_t s4;
		cpu_isa_pkg::word_t s5;
		cpu_isa_pkg::word_t s6;
		a  = 16'h003c;
		b  = 16'h0015;
		s3 = a + b;
		s4 = s3 - a;
		s5 = s4 & a;
		s6 = s3 | s5;
		clear_mems();
		put(enc_li(3'd1, a[7:0]));
		put(enc_li(3'd2, b[7:0]));
		// distance 1 on r2, distance 2 on r1
		put(enc_r(cpu_isa_pkg::OP_ADDU, 3'd3, 3'd1, 3'd2));
		put(enc_r(cpu_isa_pkg::OP_SUBU, 3'd4, 3'd3, 3'd1));
		put(enc_r(cpu_isa_pkg::OP_AND, 3'd5, 3'd4, 3'd1));
		// r3 read while it is written back
		put(enc_r(cpu_isa_pkg::OP_OR, 3'd6, 3'd3, 3'd5));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd3, 3'd0, 6'h10));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd4, 3'd0, 6'h11));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd5, 3'd0, 6'h12));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd6, 3'd0, 6'h13));
		put({cpu_isa_pkg::OP_HALT, 12'h000});
		run_program("arith");
		check_word(8'h10, s3, "addu");
		check_word(8'h11, s4, "subu");
		check_word(8'h12, s5, "and");
		check_word(8'h13, s6, "or");
	endtask

	task automatic imm_test();
		logic [7:0] i8;
		logic [5:0] neg6;
		logic [5:0] pos6;
		cpu_isa_pkg::word_t r1;
		i8   = $random(seed);
		neg6 = $random(seed);
		pos6 = $random(seed);
		// top bit set so zero extension shows
		i8   = i8 | 8'h80;
		neg6 = neg6 | 6'h20;
		pos6 = pos6 & 6'h1f;
		r1   = {8'h00, i8};
		clear_mems();
		put(enc_li(3'd1, i8));
		put(enc_i(cpu_isa_pkg::OP_ADDIU, 3'd2, 3'd1, neg6));
		put(enc_i(cpu_isa_pkg::OP_ADDIU, 3'd3, 3'd1, pos6));
		put(enc_i(cpu_isa_pkg::OP_ADDIU, 3'd4, 3'd0, neg6));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd1, 3'd0, 6'h18));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd2, 3'd0, 6'h19));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd3, 3'd0, 6'h1a));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd4, 3'd0, 6'h1b));
		put({cpu_isa_pkg::OP_HALT, 12'h000});
		run_program("immediates");
		check_word(8'h18, r1, "li zero extension");
		check_word(8'h19, r1 + sext6(neg6), "addiu negative");
		check_word(8'h1a, r1 + sext6(pos6), "addiu positive");
		check_word(8'h1b, sext6(neg6), "addiu sign extension");
	endtask

	task automatic load_store_test();
		cpu_isa_pkg::word_t v0;
		cpu_isa_pkg::word_t v1;
		v0 = 16'h1234;
		v1 = 16'h8ff1;
		clear_mems();
		dmem[8'h30] <= v0;
		dmem[8'h31] <= v1;
		put(enc_li(3'd1, 8'h30));
		put(enc_i(cpu_isa_pkg::OP_LW, 3'd2, 3'd1, 6'h00));
		// load-use, one stall
		put(enc_i(cpu_isa_pkg::OP_ADDIU, 3'd3, 3'd2, 6'h05));
		put(enc_i(cpu_isa_pkg::OP_LW, 3'd4, 3'd1, 6'h01));
		put(enc_r(cpu_isa_pkg::OP_ADDU, 3'd5, 3'd4, 3'd2));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd3, 3'd1, 6'h08));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd5, 3'd1, 6'h09));
		// negative offset, 0x30 - 16
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd4, 3'd1, 6'h30));
		put({cpu_isa_pkg::OP_HALT, 12'h000});
		run_program("load/store");
		check_word(8'h38, v0 + 16'd5, "load then addiu");
		check_word(8'h39, v1 + v0, "load then addu");
		check_word(8'h20, v1, "store with negative offset");
	endtask

	task automatic branch_test();
		clear_mems();
		dmem[8'h1f] <= 16'h0000;
		put(enc_li(3'd7, 8'hee));
		put(enc_li(3'd1, 8'h00));
		put(enc_li(3'd2, 8'h07));
		// r2 still in ex, not taken
		put(enc_i(cpu_isa_pkg::OP_BEQZ, 3'd0, 3'd2, 6'h01));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd2, 3'd0, 6'h01));
		put(enc_i(cpu_isa_pkg::OP_BNEZ, 3'd0, 3'd2, 6'h02));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd7, 3'd0, 6'h02));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd7, 3'd0, 6'h03));
		put(enc_i(cpu_isa_pkg::OP_LW, 3'd3, 3'd0, 6'h1f));
		// branch on a fresh load
		put(enc_i(cpu_isa_pkg::OP_BEQZ, 3'd0, 3'd3, 6'h01));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd7, 3'd0, 6'h04));
		put({cpu_isa_pkg::OP_B, 3'd0, 9'h002});
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd7, 3'd0, 6'h05));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd7, 3'd0, 6'h06));
		put(enc_i(cpu_isa_pkg::OP_ADDIU, 3'd4, 3'd1, 6'h01));
		put(enc_i(cpu_isa_pkg::OP_BNEZ, 3'd0, 3'd4, 6'h01));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd7, 3'd0, 6'h07));
		put(enc_i(cpu_isa_pkg::OP_BNEZ, 3'd0, 3'd1, 6'h01));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd4, 3'd0, 6'h08));
		put({cpu_isa_pkg::OP_HALT, 12'h000});
		run_program("branches");
		check_word(8'h01, 16'h0007, "not-taken beqz path");
		check_word(8'h08, 16'h0001, "not-taken bnez path");
		// squashed and skipped markers
		for (int a = 2; a <= 7; a++) begin
			check_word(a, fill_of(a), "marker store leaked");
		end
	endtask

	task automatic halt_run(input string name);
		clear_mems();
		put(enc_li(3'd1, 8'h5a));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd1, 3'd0, 6'h10));
		put({cpu_isa_pkg::OP_HALT, 12'h000});
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd1, 3'd0, 6'h11));
		put(enc_i(cpu_isa_pkg::OP_SW, 3'd1, 3'd0, 6'h12));
		run_program(name);
		check_word(8'h10, 16'h005a, "store before halt");
		check_word(8'h11, fill_of(8'h11), "store after halt");
		check_word(8'h12, fill_of(8'h12), "store after halt");
	endtask

	task automatic halt_reset_test();
		halt_run("halt first run");
		// halted stays up, pc parked one past the halt at 2
		repeat (12) begin
			@(negedge clk);
			checks++;
			assert (halted === 1'b1 && dmem_we === 1'b0) else begin
				errors++;
				$display("halt flag dropped or a store happened after halt");
			end
			checks++;
			assert (imem_addr === 8'd3) else begin
				errors++;
				$display("Mismatch at %0t: fetch address %02h after halt, expected 03",
					$time, imem_addr);
			end
		end
		reset_during_stores();
		halt_run("halt second run");
	endtask

	////////////////////////////////////////////////////////////
	// main
	////////////////////////////////////////////////////////////
	initial begin
		int cyc;
		rst_q    <= 1'b1;
		errors   = 0;
		checks   = 0;
		seed     = 71;
		clear_mems();
		cyc = 0;
		while (por_rst_n !== 1'b1 && cyc < 20) begin
			@(posedge clk);
			cyc++;
		end
		if (por_rst_n !== 1'b1) begin
			errors++;
			$display("power-on reset never released");
		end
		arith_test();
		imm_test();
		load_store_test();
		branch_test();
		halt_reset_test();
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic rst_n_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// power-on reset, low for 4 cycles
	initial begin
		rst_n_o <= 1'b0;
		repeat (4) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

/* design/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

	// alu select
	typedef logic [1:0] alu_op_t;

	localparam alu_op_t ALU_ADD = 2'd0;
	localparam alu_op_t ALU_SUB = 2'd1;
	localparam alu_op_t ALU_AND = 2'd2;
	localparam alu_op_t ALU_OR  = 2'd3;

	// operand source in execute
	typedef logic [1:0] fwd_sel_t;

	localparam fwd_sel_t FWD_REG   = 2'd0;
	localparam fwd_sel_t FWD_EXMEM = 2'd1;
	localparam fwd_sel_t FWD_MEMWB = 2'd2;

	// writeback source
	typedef logic wb_src_t;

	localparam wb_src_t WB_ALU = 1'b0;
	localparam wb_src_t WB_MEM = 1'b1;

endpackage

`default_nettype wire

/* design/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	// datapath widths
	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_idx_t;
	typedef logic [7:0]  iaddr_t;
	typedef logic [7:0]  daddr_t;
	typedef logic [3:0]  opcode_t;

	// opcodes, instruction bits 15..12
	localparam opcode_t OP_NOP   = 4'h0;
	localparam opcode_t OP_ADDU  = 4'h1;
	localparam opcode_t OP_SUBU  = 4'h2;
	localparam opcode_t OP_AND   = 4'h3;
	localparam opcode_t OP_OR    = 4'h4;
	localparam opcode_t OP_LI    = 4'h5;
	localparam opcode_t OP_ADDIU = 4'h6;
	localparam opcode_t OP_LW    = 4'h7;
	localparam opcode_t OP_SW    = 4'h8;
	localparam opcode_t OP_B     = 4'h9;
	localparam opcode_t OP_BEQZ  = 4'ha;
	localparam opcode_t OP_BNEZ  = 4'hb;
	localparam opcode_t OP_HALT  = 4'hf;

	// all-zero word decodes as nop
	localparam word_t NOP_INSTR = 16'h0000;

	// field positions
	localparam int OP_HI = 15;
	localparam int OP_LO = 12;
	localparam int RD_HI = 11;
	localparam int RD_LO = 9;
	localparam int RS_HI = 8;
	localparam int RS_LO = 6;
	localparam int RT_HI = 5;
	localparam int RT_LO = 3;
	localparam int IMM6_HI = 5;
	localparam int IMM8_HI = 7;
	localparam int OFF9_HI = 8;
	localparam int IMM_LO = 0;

endpackage

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire                   clk,
	input  wire                   rst_n_i,
	output cpu_isa_pkg::iaddr_t   imem_addr_o,
	input  wire cpu_isa_pkg::word_t  imem_data_i,
	output cpu_isa_pkg::daddr_t   dmem_addr_o,
	output cpu_isa_pkg::word_t    dmem_wdata_o,
	output logic                  dmem_we_o,
	input  wire cpu_isa_pkg::word_t  dmem_rdata_i,
	output logic                  halted_o
);

	// if -> id
	cpu_isa_pkg::word_t    id_instr;
	cpu_isa_pkg::iaddr_t   id_pc;
	// id side
	logic                  stall, redirect, halt;
	cpu_isa_pkg::iaddr_t   target;
	cpu_isa_pkg::reg_idx_t rs_idx, rt_idx;
	cpu_isa_pkg::word_t    rs_data, rt_data;
	logic                  uses_rs, uses_rt, is_branch;
	// id/ex
	cpu_isa_pkg::reg_idx_t ex_dst, ex_rs_idx, ex_rt_idx;
	logic                  ex_wr, ex_load, ex_store, ex_halt, ex_b_is_reg;
	cpu_ctrl_pkg::alu_op_t ex_alu_op;
	cpu_isa_pkg::word_t    ex_a, ex_b, ex_store_data;
	// ex/mem
	cpu_isa_pkg::reg_idx_t mem_dst;
	logic                  mem_wr, mem_load, mem_store, mem_halt;
	cpu_isa_pkg::word_t    mem_res, mem_store_data;
	// mem/wb
	logic                  wb_we;
	cpu_isa_pkg::reg_idx_t wb_idx;
	cpu_isa_pkg::word_t    wb_data;

	////////////////////////////////////////////////////////////
	// front end
	////////////////////////////////////////////////////////////
	fetch_stage fetch_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.stall_i(stall), .redirect_i(redirect), .target_i(target), .halt_i(halt),
		.imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
		.instr_o(id_instr), .pc_o(id_pc)
	);

	decode_stage decode_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.instr_i(id_instr), .pc_i(id_pc), .stall_i(stall),
		.rs_data_i(rs_data), .rt_data_i(rt_data), .rs_idx_o(rs_idx), .rt_idx_o(rt_idx),
		// branch compare forwarding from ex/mem
		.exmem_dst_i(mem_dst), .exmem_wr_i(mem_wr), .exmem_res_i(mem_res),
		.redirect_o(redirect), .target_o(target), .halt_o(halt),
		.uses_rs_o(uses_rs), .uses_rt_o(uses_rt), .is_branch_o(is_branch),
		.ex_dst_o(ex_dst), .ex_wr_o(ex_wr), .ex_load_o(ex_load), .ex_store_o(ex_store),
		.ex_halt_o(ex_halt), .ex_alu_op_o(ex_alu_op), .ex_a_o(ex_a), .ex_b_o(ex_b),
		.ex_store_data_o(ex_store_data), .ex_rs_idx_o(ex_rs_idx), .ex_rt_idx_o(ex_rt_idx),
		.ex_b_is_reg_o(ex_b_is_reg)
	);

	reg_file regs_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.rd_idx_a_i(rs_idx), .rd_idx_b_i(rt_idx), .rd_data_a_o(rs_data), .rd_data_b_o(rt_data),
		.we_i(wb_we), .wr_idx_i(wb_idx), .wr_data_i(wb_data)
	);

	hazard_unit hazard_i (
		.id_rs_idx_i(rs_idx), .id_rt_idx_i(rt_idx),
		.id_uses_rs_i(uses_rs), .id_uses_rt_i(uses_rt), .id_is_branch_i(is_branch),
		.ex_dst_i(ex_dst), .ex_wr_i(ex_wr), .ex_load_i(ex_load),
		.mem_dst_i(mem_dst), .mem_load_i(mem_load),
		.stall_o(stall)
	);

	////////////////////////////////////////////////////////////
	// back end
	////////////////////////////////////////////////////////////
	execute_stage execute_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.ex_dst_i(ex_dst), .ex_wr_i(ex_wr), .ex_load_i(ex_load), .ex_store_i(ex_store),
		.ex_halt_i(ex_halt), .ex_alu_op_i(ex_alu_op), .ex_a_i(ex_a), .ex_b_i(ex_b),
		.ex_store_data_i(ex_store_data), .ex_rs_idx_i(ex_rs_idx), .ex_rt_idx_i(ex_rt_idx),
		.ex_b_is_reg_i(ex_b_is_reg),
		// own ex/mem fed back, plus writeback
		.exmem_dst_i(mem_dst), .exmem_wr_i(mem_wr), .exmem_res_i(mem_res),
		.memwb_wr_i(wb_we), .memwb_dst_i(wb_idx), .memwb_data_i(wb_data),
		.mem_dst_o(mem_dst), .mem_wr_o(mem_wr), .mem_load_o(mem_load),
		.mem_store_o(mem_store), .mem_halt_o(mem_halt),
		.mem_res_o(mem_res), .mem_store_data_o(mem_store_data)
	);

	mem_wb_stage mem_wb_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.mem_dst_i(mem_dst), .mem_wr_i(mem_wr), .mem_load_i(mem_load),
		.mem_store_i(mem_store), .mem_halt_i(mem_halt),
		.mem_res_i(mem_res), .mem_store_data_i(mem_store_data),
		.dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
		.dmem_rdata_i(dmem_rdata_i),
		.wb_we_o(wb_we), .wb_idx_o(wb_idx), .wb_data_o(wb_data), .halted_o(halted_o)
	);

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  wire cpu_isa_pkg::word_t    instr_i,
	input  wire cpu_isa_pkg::iaddr_t   pc_i,
	input  wire                     stall_i,
	input  wire cpu_isa_pkg::word_t    rs_data_i,
	input  wire cpu_isa_pkg::word_t    rt_data_i,
	output cpu_isa_pkg::reg_idx_t   rs_idx_o,
	output cpu_isa_pkg::reg_idx_t   rt_idx_o,
	input  wire cpu_isa_pkg::reg_idx_t exmem_dst_i,
	input  wire                     exmem_wr_i,
	input  wire cpu_isa_pkg::word_t    exmem_res_i,
	output logic                    redirect_o,
	output cpu_isa_pkg::iaddr_t     target_o,
	output logic                    halt_o,
	output logic                    uses_rs_o,
	output logic                    uses_rt_o,
	output logic                    is_branch_o,
	output cpu_isa_pkg::reg_idx_t   ex_dst_o,
	output logic                    ex_wr_o,
	output logic                    ex_load_o,
	output logic                    ex_store_o,
	output logic                    ex_halt_o,
	output cpu_ctrl_pkg::alu_op_t   ex_alu_op_o,
	output cpu_isa_pkg::word_t      ex_a_o,
	output cpu_isa_pkg::word_t      ex_b_o,
	output cpu_isa_pkg::word_t      ex_store_data_o,
	output cpu_isa_pkg::reg_idx_t   ex_rs_idx_o,
	output cpu_isa_pkg::reg_idx_t   ex_rt_idx_o,
	output logic                    ex_b_is_reg_o
);

	cpu_isa_pkg::opcode_t  opcode;
	cpu_isa_pkg::reg_idx_t rd_idx;
	cpu_isa_pkg::word_t    imm6_ext;
	cpu_isa_pkg::word_t    imm8_ext;
	cpu_isa_pkg::word_t    rs_fwd;
	cpu_ctrl_pkg::alu_op_t alu_op;
	logic [8:0]            br_sum;
	logic                  is_rtype;
	logic                  is_li;
	logic                  is_lw;
	logic                  is_sw;
	logic                  is_b;
	logic                  is_cond;
	logic                  cond_true;
	logic                  writes_rd;

	//////////////////////////////////////////////////////////
	// field decode
	//////////////////////////////////////////////////////////
	assign opcode   = instr_i[cpu_isa_pkg::OP_HI:cpu_isa_pkg::OP_LO];
	assign rd_idx   = instr_i[cpu_isa_pkg::RD_HI:cpu_isa_pkg::RD_LO];
	assign is_rtype = (opcode == cpu_isa_pkg::OP_ADDU) || (opcode == cpu_isa_pkg::OP_SUBU)
		|| (opcode == cpu_isa_pkg::OP_AND) || (opcode == cpu_isa_pkg::OP_OR);
	assign is_li    = (opcode == cpu_isa_pkg::OP_LI);
	assign is_lw    = (opcode == cpu_isa_pkg::OP_LW);
	assign is_sw    = (opcode == cpu_isa_pkg::OP_SW);
	assign is_b     = (opcode == cpu_isa_pkg::OP_B);
	assign is_cond  = (opcode == cpu_isa_pkg::OP_BEQZ) || (opcode == cpu_isa_pkg::OP_BNEZ);
	assign halt_o   = (opcode == cpu_isa_pkg::OP_HALT) && !stall_i;
	assign writes_rd = is_rtype || is_li || is_lw || (opcode == cpu_isa_pkg::OP_ADDIU);

	// sw reads its data reg through the second port
	assign rs_idx_o = instr_i[cpu_isa_pkg::RS_HI:cpu_isa_pkg::RS_LO];
	assign rt_idx_o = is_sw ? rd_idx : instr_i[cpu_isa_pkg::RT_HI:cpu_isa_pkg::RT_LO];

	assign uses_rs_o   = is_rtype || is_lw || is_sw || is_cond
		|| (opcode == cpu_isa_pkg::OP_ADDIU);
	assign uses_rt_o   = is_rtype || is_sw;
	assign is_branch_o = is_cond;

	// immediates
	assign imm6_ext = {{10{instr_i[cpu_isa_pkg::IMM6_HI]}},
		instr_i[cpu_isa_pkg::IMM6_HI:cpu_isa_pkg::IMM_LO]};
	assign imm8_ext = {8'h00, instr_i[cpu_isa_pkg::IMM8_HI:cpu_isa_pkg::IMM_LO]};

	always_comb begin
		case (opcode)
			cpu_isa_pkg::OP_SUBU: alu_op = cpu_ctrl_pkg::ALU_SUB;
			cpu_isa_pkg::OP_AND:  alu_op = cpu_ctrl_pkg::ALU_AND;
			// li is or of the immediate with itself
			cpu_isa_pkg::OP_OR,
			cpu_isa_pkg::OP_LI:   alu_op = cpu_ctrl_pkg::ALU_OR;
			default:              alu_op = cpu_ctrl_pkg::ALU_ADD;
		endcase
	end

	//////////////////////////////////////////////////////////
	// branch resolve
	//////////////////////////////////////////////////////////
	// alu result in mem, older writers come through the regfile bypass
	assign rs_fwd = (exmem_wr_i && (exmem_dst_i == rs_idx_o)) ? exmem_res_i : rs_data_i;

	assign cond_true = (opcode == cpu_isa_pkg::OP_BEQZ) ? (rs_fwd == '0) : (rs_fwd != '0);
	assign redirect_o = !stall_i && (is_b || (is_cond && cond_true));

	// target is own address + 1 + offset, wraps at 256
	assign br_sum = {1'b0, pc_i} + 9'd1 + (is_b
		? instr_i[cpu_isa_pkg::OFF9_HI:cpu_isa_pkg::IMM_LO]
		: {{3{instr_i[cpu_isa_pkg::IMM6_HI]}}, instr_i[cpu_isa_pkg::IMM6_HI:cpu_isa_pkg::IMM_LO]});
	assign target_o = br_sum[7:0];

	//////////////////////////////////////////////////////////
	// id/ex
	//////////////////////////////////////////////////////////
	// control, bubble on stall
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_wr_o    <= 1'b0;
			ex_load_o  <= 1'b0;
			ex_store_o <= 1'b0;
			ex_halt_o  <= 1'b0;
		end else begin
			ex_wr_o    <= writes_rd && !stall_i;
			ex_load_o  <= is_lw && !stall_i;
			ex_store_o <= is_sw && !stall_i;
			ex_halt_o  <= halt_o;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		ex_dst_o        <= rd_idx;
		ex_alu_op_o     <= alu_op;
		ex_a_o          <= is_li ? imm8_ext : rs_data_i;
		ex_b_o          <= is_rtype ? rt_data_i : (is_li ? imm8_ext : imm6_ext);
		ex_store_data_o <= rt_data_i;
		ex_rs_idx_o     <= rs_idx_o;
		ex_rt_idx_o     <= rt_idx_o;
		ex_b_is_reg_o   <= is_rtype;
	end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire cpu_isa_pkg::reg_idx_t  ex_dst_i,
	input  wire                      ex_wr_i,
	input  wire                      ex_load_i,
	input  wire                      ex_store_i,
	input  wire                      ex_halt_i,
	input  wire cpu_ctrl_pkg::alu_op_t  ex_alu_op_i,
	input  wire cpu_isa_pkg::word_t     ex_a_i,
	input  wire cpu_isa_pkg::word_t     ex_b_i,
	input  wire cpu_isa_pkg::word_t     ex_store_data_i,
	input  wire cpu_isa_pkg::reg_idx_t  ex_rs_idx_i,
	input  wire cpu_isa_pkg::reg_idx_t  ex_rt_idx_i,
	input  wire                      ex_b_is_reg_i,
	input  wire cpu_isa_pkg::reg_idx_t  exmem_dst_i,
	input  wire                      exmem_wr_i,
	input  wire cpu_isa_pkg::word_t     exmem_res_i,
	input  wire                      memwb_wr_i,
	input  wire cpu_isa_pkg::reg_idx_t  memwb_dst_i,
	input  wire cpu_isa_pkg::word_t     memwb_data_i,
	output cpu_isa_pkg::reg_idx_t    mem_dst_o,
	output logic                     mem_wr_o,
	output logic                     mem_load_o,
	output logic                     mem_store_o,
	output logic                     mem_halt_o,
	output cpu_isa_pkg::word_t       mem_res_o,
	output cpu_isa_pkg::word_t       mem_store_data_o
);

	cpu_ctrl_pkg::fwd_sel_t a_sel;
	cpu_ctrl_pkg::fwd_sel_t rt_sel;
	cpu_isa_pkg::word_t     a_val;
	cpu_isa_pkg::word_t     rt_val;
	cpu_isa_pkg::word_t     b_val;
	cpu_isa_pkg::word_t     alu_res;
	logic                   a_is_reg;

	// ex/mem is younger, so it wins
	function automatic cpu_ctrl_pkg::fwd_sel_t pick_src(input cpu_isa_pkg::reg_idx_t idx);
		if (exmem_wr_i && (exmem_dst_i == idx)) begin
			return cpu_ctrl_pkg::FWD_EXMEM;
		end else if (memwb_wr_i && (memwb_dst_i == idx)) begin
			return cpu_ctrl_pkg::FWD_MEMWB;
		end
		return cpu_ctrl_pkg::FWD_REG;
	endfunction

	function automatic cpu_isa_pkg::word_t fwd_mux(input cpu_ctrl_pkg::fwd_sel_t sel,
		input cpu_isa_pkg::word_t reg_val);
		case (sel)
			cpu_ctrl_pkg::FWD_EXMEM: return exmem_res_i;
			cpu_ctrl_pkg::FWD_MEMWB: return memwb_data_i;
			default:                 return reg_val;
		endcase
	endfunction

	//////////////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////////////
	// li is the only immediate form not using add, its a is the immediate
	assign a_is_reg = ex_b_is_reg_i || (ex_alu_op_i == cpu_ctrl_pkg::ALU_ADD);
	assign a_sel    = a_is_reg ? pick_src(ex_rs_idx_i) : cpu_ctrl_pkg::FWD_REG;
	assign rt_sel   = pick_src(ex_rt_idx_i);
	assign a_val    = fwd_mux(a_sel, ex_a_i);
	// rt carries the store data for sw
	assign rt_val   = fwd_mux(rt_sel, ex_store_data_i);
	assign b_val    = ex_b_is_reg_i ? rt_val : ex_b_i;

	// alu, also forms the data address
	always_comb begin
		case (ex_alu_op_i)
			cpu_ctrl_pkg::ALU_SUB: alu_res = a_val - b_val;
			cpu_ctrl_pkg::ALU_AND: alu_res = a_val & b_val;
			cpu_ctrl_pkg::ALU_OR:  alu_res = a_val | b_val;
			default:               alu_res = a_val + b_val;
		endcase
	end

	//////////////////////////////////////////////////////////
	// ex/mem
	//////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_wr_o    <= 1'b0;
			mem_load_o  <= 1'b0;
			mem_store_o <= 1'b0;
			mem_halt_o  <= 1'b0;
		end else begin
			mem_wr_o    <= ex_wr_i;
			mem_load_o  <= ex_load_i;
			mem_store_o <= ex_store_i;
			mem_halt_o  <= ex_halt_i;
		end
	end

	always_ff @(posedge clk) begin
		mem_dst_o        <= ex_dst_i;
		mem_res_o        <= alu_res;
		mem_store_data_o <= rt_val;
	end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire                  clk,
	input  wire                  rst_n_i,
	input  wire                  stall_i,
	input  wire                  redirect_i,
	input  wire cpu_isa_pkg::iaddr_t target_i,
	input  wire                  halt_i,
	output cpu_isa_pkg::iaddr_t  imem_addr_o,
	input  wire cpu_isa_pkg::word_t imem_data_i,
	output cpu_isa_pkg::word_t   instr_o,
	output cpu_isa_pkg::iaddr_t  pc_o
);

	cpu_isa_pkg::iaddr_t pc_q;
	logic                halt_q;

	// pc drives imem directly, read is same cycle
	assign imem_addr_o = pc_q;

	//////////////////////////////////////////////////////////
	// pc and if/id
	//////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q    <= '0;
			halt_q  <= 1'b0;
			instr_o <= cpu_isa_pkg::NOP_INSTR;
			pc_o    <= '0;
		end else if (redirect_i) begin
			// taken branch, squash the slot behind it
			pc_q    <= target_i;
			instr_o <= cpu_isa_pkg::NOP_INSTR;
		end else if (stall_i) begin
			// hold pc and if/id
		end else if (halt_i || halt_q) begin
			// frozen after halt, feed nops only
			halt_q  <= 1'b1;
			instr_o <= cpu_isa_pkg::NOP_INSTR;
		end else begin
			pc_q    <= pc_q + 8'd1;
			instr_o <= imem_data_i;
			pc_o    <= pc_q;
		end
	end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  wire cpu_isa_pkg::reg_idx_t id_rs_idx_i,
	input  wire cpu_isa_pkg::reg_idx_t id_rt_idx_i,
	input  wire                     id_uses_rs_i,
	input  wire                     id_uses_rt_i,
	input  wire                     id_is_branch_i,
	input  wire cpu_isa_pkg::reg_idx_t ex_dst_i,
	input  wire                     ex_wr_i,
	input  wire                     ex_load_i,
	input  wire cpu_isa_pkg::reg_idx_t mem_dst_i,
	input  wire                     mem_load_i,
	output logic                    stall_o
);

	logic dep_ex;
	logic dep_mem;

	// decode source written by the instruction in ex
	assign dep_ex = ex_wr_i && ((id_uses_rs_i && (ex_dst_i == id_rs_idx_i))
		|| (id_uses_rt_i && (ex_dst_i == id_rt_idx_i)));

	// load data only exists at the end of mem
	assign dep_mem = mem_load_i && ((id_uses_rs_i && (mem_dst_i == id_rs_idx_i))
		|| (id_uses_rt_i && (mem_dst_i == id_rt_idx_i)));

	// load-use, or branch compare that cannot be forwarded yet
	assign stall_o = (dep_ex && ex_load_i) || (id_is_branch_i && (dep_ex || dep_mem));

endmodule

`default_nettype wire

/* design/mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  wire cpu_isa_pkg::reg_idx_t mem_dst_i,
	input  wire                     mem_wr_i,
	input  wire                     mem_load_i,
	input  wire                     mem_store_i,
	input  wire                     mem_halt_i,
	input  wire cpu_isa_pkg::word_t    mem_res_i,
	input  wire cpu_isa_pkg::word_t    mem_store_data_i,
	output cpu_isa_pkg::daddr_t     dmem_addr_o,
	output cpu_isa_pkg::word_t      dmem_wdata_o,
	output logic                    dmem_we_o,
	input  wire cpu_isa_pkg::word_t    dmem_rdata_i,
	output logic                    wb_we_o,
	output cpu_isa_pkg::reg_idx_t   wb_idx_o,
	output cpu_isa_pkg::word_t      wb_data_o,
	output logic                    halted_o
);

	cpu_ctrl_pkg::wb_src_t wb_src_q;
	cpu_isa_pkg::word_t    wb_alu_q;
	cpu_isa_pkg::word_t    wb_load_q;

	// data port, low byte of the alu result is the word address
	assign dmem_addr_o  = mem_res_i[7:0];
	assign dmem_wdata_o = mem_store_data_i;
	assign dmem_we_o    = mem_store_i;

	//////////////////////////////////////////////////////////
	// mem/wb
	//////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_we_o  <= 1'b0;
			halted_o <= 1'b0;
		end else begin
			wb_we_o <= mem_wr_i;
			// sticky until reset
			if (mem_halt_i) begin
				halted_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_idx_o  <= mem_dst_i;
		wb_src_q  <= mem_load_i ? cpu_ctrl_pkg::WB_MEM : cpu_ctrl_pkg::WB_ALU;
		wb_alu_q  <= mem_res_i;
		wb_load_q <= dmem_rdata_i;
	end

	assign wb_data_o = (wb_src_q == cpu_ctrl_pkg::WB_MEM) ? wb_load_q : wb_alu_q;

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  wire cpu_isa_pkg::reg_idx_t rd_idx_a_i,
	input  wire cpu_isa_pkg::reg_idx_t rd_idx_b_i,
	output cpu_isa_pkg::word_t      rd_data_a_o,
	output cpu_isa_pkg::word_t      rd_data_b_o,
	input  wire                     we_i,
	input  wire cpu_isa_pkg::reg_idx_t wr_idx_i,
	input  wire cpu_isa_pkg::word_t    wr_data_i
);

	cpu_isa_pkg::word_t regs [8];

	// all eight are plain registers
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// write in wb is visible to decode in the same cycle
	assign rd_data_a_o = (we_i && (wr_idx_i == rd_idx_a_i)) ? wr_data_i : regs[rd_idx_a_i];
	assign rd_data_b_o = (we_i && (wr_idx_i == rd_idx_b_i)) ? wr_data_i : regs[rd_idx_b_i];

endmodule

`default_nettype wire

/* filelist.f */
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
bench/tb_clock.sv
bench/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
	-f filelist.f -o cpu_sim > build.log 2>&1 \
	&& ./obj_dir/cpu_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
exit 0
